// File: src/dbg_macros.svh
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// serial bit length in clock cycles
`define DBG_CLKS_PER_BIT 16

// encoder wait after each character start
`define DBG_TX_GAP 4

// register bank geometry
`define DBG_NUM_REGS 16
`define DBG_DATA_W 16
`define DBG_ADDR_W 4

`endif

// File: src/dbg_pkg.sv
`include "dbg_macros.svh"

package dbg_pkg;

	// request from the command decoder to the register bank
	typedef struct packed {
		logic                   write;
		logic [`DBG_ADDR_W-1:0] addr;
		logic [`DBG_DATA_W-1:0] wdata;
	} bus_req_t;

	// kind of answer, selects the tag digit
	typedef enum logic [1:0] {
		RSP_READ,
		RSP_WRITE,
		RSP_ERROR
	} rsp_kind_e;

	typedef struct packed {
		rsp_kind_e              kind;
		logic [`DBG_DATA_W-1:0] data;
	} rsp_t;

	// command parser states
	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_ADDR,
		DEC_DATA,
		DEC_EOL,
		DEC_SKIP
	} dec_state_e;

	// serial frame states, rx and tx
	typedef enum logic [1:0] {
		U_IDLE,
		U_START,
		U_DATA,
		U_STOP
	} uart_state_e;

endpackage

// File: src/uart_rx.sv
`include "dbg_macros.svh"

module uart_rx (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_rx,
	output logic [7:0] o_data,
	output logic       o_valid
);
	import dbg_pkg::*;

	localparam int CNT_W = $clog2(`DBG_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DBG_CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`DBG_CLKS_PER_BIT / 2 - 1);

	uart_state_e      state;
	logic             rx_meta;
	logic             rx_sync;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;
	logic             sample_data;
	logic             stop_ok;

	// centre of a data bit
	assign sample_data = (state == U_DATA) && (cnt == CNT_LAST);
	// centre of stop bit, line must be high
	assign stop_ok = (state == U_STOP) && (cnt == CNT_LAST) && rx_sync;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			state   <= U_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			o_valid <= 1'b0;
		end else begin
			// two flop synchronizer, idles high
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
			o_valid <= stop_ok;
			case (state)
				U_IDLE: begin
					cnt <= '0;
					if (!rx_sync)
						state <= U_START;
				end
				U_START: begin
					// recheck half a bit later, glitches go back to idle
					if (cnt == CNT_HALF) begin
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? U_IDLE : U_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				U_DATA: begin
					if (cnt == CNT_LAST) begin
						cnt <= '0;
						if (bit_idx == 3'd7)
							state <= U_STOP;
						bit_idx <= bit_idx + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					// low stop bit just drops the byte
					if (cnt == CNT_LAST) begin
						cnt   <= '0;
						state <= U_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb first, new bit enters at the top
	always_ff @(posedge i_clk) begin
		if (sample_data)
			shift <= {rx_sync, shift[7:1]};
		if (stop_ok)
			o_data <= shift;
	end

endmodule

// File: src/uart_tx.sv
`include "dbg_macros.svh"

module uart_tx (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic [7:0] i_data,
	input  logic       i_start,
	output logic       o_tx,
	output logic       o_busy
);
	import dbg_pkg::*;

	localparam int CNT_W = $clog2(`DBG_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DBG_CLKS_PER_BIT - 1);

	uart_state_e      state;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift;
	logic             bit_end;

	assign bit_end = (cnt == CNT_LAST);
	// busy for the whole frame, stop bit included
	assign o_busy = (state != U_IDLE);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state   <= U_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			o_tx    <= 1'b1;
		end else begin
			cnt <= (state == U_IDLE || bit_end) ? '0 : cnt + 1'b1;
			case (state)
				U_IDLE: begin
					if (i_start) begin
						o_tx  <= 1'b0;
						state <= U_START;
					end
				end
				U_START: begin
					if (bit_end) begin
						o_tx    <= shift[0];
						bit_idx <= '0;
						state   <= U_DATA;
					end
				end
				U_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							o_tx  <= 1'b1;
							state <= U_STOP;
						end else begin
							o_tx <= shift[1];
						end
					end
				end
				default: begin
					if (bit_end)
						state <= U_IDLE;
				end
			endcase
		end
	end

	// byte held here, shifted down once per data bit
	always_ff @(posedge i_clk) begin
		if (state == U_IDLE && i_start)
			shift <= i_data;
		else if (state == U_DATA && bit_end)
			shift <= {1'b0, shift[7:1]};
	end

endmodule

// File: src/hex_cmd_decoder.sv
`include "dbg_macros.svh"

module hex_cmd_decoder (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic [7:0]       i_byte,
	input  logic             i_valid,
	input  logic             i_busy,
	output dbg_pkg::bus_req_t o_req,
	output logic             o_req_stb,
	output logic             o_err
);
	import dbg_pkg::*;

	localparam int DATA_DIGITS = `DBG_DATA_W / 4;
	localparam int DCNT_W = $clog2(DATA_DIGITS);
	localparam logic [DCNT_W-1:0] DCNT_LAST = DCNT_W'(DATA_DIGITS - 1);
	localparam logic [7:0] CHAR_CR = 8'h0d;
	localparam logic [7:0] CHAR_LF = 8'h0a;

	dec_state_e        state;
	logic [DCNT_W-1:0] digit_cnt;
	logic              accept;
	logic              is_eol;
	logic              is_rd;
	logic              is_wr;
	logic [4:0]        hex;
	logic              is_hex;
	logic [3:0]        nib;

	// {is_hex, nibble}, either case
	function automatic logic [4:0] hex_val(input logic [7:0] c);
		if (c >= "0" && c <= "9")
			hex_val = {1'b1, c[3:0]};
		else if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f"))
			hex_val = {1'b1, c[3:0] + 4'd9};
		else
			hex_val = 5'd0;
	endfunction

	assign hex    = hex_val(i_byte);
	assign is_hex = hex[4];
	assign nib    = hex[3:0];
	assign is_eol = (i_byte == CHAR_CR) || (i_byte == CHAR_LF);
	assign is_rd  = (i_byte == "r") || (i_byte == "R");
	assign is_wr  = (i_byte == "w") || (i_byte == "W");
	// bytes dropped while a response goes out
	// skip still hunts for the terminator of the bad line meanwhile
	assign accept = i_valid && (!i_busy || state == DEC_SKIP);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state     <= DEC_IDLE;
			digit_cnt <= '0;
			o_req     <= '0;
			o_req_stb <= 1'b0;
			o_err     <= 1'b0;
		end else begin
			o_req_stb <= 1'b0;
			o_err     <= 1'b0;
			if (accept) begin
				case (state)
					DEC_IDLE: begin
						// stray terminators, e.g. lf after cr, ignored
						if (is_rd || is_wr) begin
							o_req.write <= is_wr;
							state       <= DEC_ADDR;
						end else if (!is_eol) begin
							o_err <= 1'b1;
							state <= DEC_SKIP;
						end
					end
					DEC_ADDR: begin
						digit_cnt <= '0;
						if (is_hex) begin
							o_req.addr <= nib;
							state      <= o_req.write ? DEC_DATA : DEC_EOL;
						end else begin
							// early terminator already ends the line
							o_err <= 1'b1;
							state <= is_eol ? DEC_IDLE : DEC_SKIP;
						end
					end
					DEC_DATA: begin
						if (is_hex) begin
							// msd first, shift up
							o_req.wdata <= {o_req.wdata[`DBG_DATA_W-5:0], nib};
							digit_cnt   <= digit_cnt + 1'b1;
							if (digit_cnt == DCNT_LAST)
								state <= DEC_EOL;
						end else begin
							o_err <= 1'b1;
							state <= is_eol ? DEC_IDLE : DEC_SKIP;
						end
					end
					DEC_EOL: begin
						if (is_eol) begin
							o_req_stb <= 1'b1;
						end else begin
							o_err <= 1'b1;
						end
						state <= is_eol ? DEC_IDLE : DEC_SKIP;
					end
					default: begin
						if (is_eol)
							state <= DEC_IDLE;
					end
				endcase
			end
		end
	end

endmodule

// File: src/dbg_regfile.sv
`include "dbg_macros.svh"

module dbg_regfile (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  dbg_pkg::bus_req_t      i_req,
	input  logic                   i_req_stb,
	output logic                   o_ack,
	output logic [`DBG_DATA_W-1:0] o_rdata,
	output logic [7:0]             o_leds
);

	logic [`DBG_DATA_W-1:0] regs [`DBG_NUM_REGS];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `DBG_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			o_ack   <= 1'b0;
			o_rdata <= '0;
			o_leds  <= '0;
		end else begin
			// ack always one cycle after the strobe
			o_ack  <= i_req_stb;
			// leds follow reg 0 low byte
			o_leds <= regs[0][7:0];
			if (i_req_stb) begin
				if (i_req.write) begin
					regs[i_req.addr] <= i_req.wdata;
					// write echoes the new value
					o_rdata <= i_req.wdata;
				end else begin
					o_rdata <= regs[i_req.addr];
				end
			end
		end
	end

endmodule

// File: src/hex_rsp_encoder.sv
`include "dbg_macros.svh"

module hex_rsp_encoder (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_ack,
	input  logic                   i_write,
	input  logic [`DBG_DATA_W-1:0] i_rdata,
	input  logic                   i_err,
	input  logic                   i_tx_busy,
	output logic [7:0]             o_char,
	output logic                   o_tx_start,
	output logic                   o_busy
);
	import dbg_pkg::*;

	// data nibbles plus tag nibble
	localparam int NUM_CHARS = `DBG_DATA_W / 4 + 1;
	localparam int REM_W = $clog2(NUM_CHARS + 1);
	localparam int GAP_W = $clog2(`DBG_TX_GAP + 1);

	rsp_t                 rsp;
	logic                 rsp_evt;
	logic [4*NUM_CHARS-1:0] word;
	logic [REM_W-1:0]     remain;
	logic [3:0]           nib;
	logic                 start_pend;
	logic [GAP_W-1:0]     gap_cnt;
	logic                 send_ok;

	function automatic logic [3:0] kind_tag(input rsp_kind_e kind);
		case (kind)
			RSP_READ:  kind_tag = 4'h2;
			RSP_WRITE: kind_tag = 4'h1;
			default:   kind_tag = 4'he;
		endcase
	endfunction

	// lowercase hex digit
	function automatic logic [7:0] nib_ascii(input logic [3:0] n);
		if (n < 4'd10)
			nib_ascii = {4'h3, n};
		else
			nib_ascii = 8'h57 + {4'h0, n};
	endfunction

	// error carries zero data
	assign rsp.kind = i_err ? RSP_ERROR : (i_write ? RSP_WRITE : RSP_READ);
	assign rsp.data = i_err ? '0 : i_rdata;
	assign rsp_evt  = i_ack || i_err;

	// tx idle, nothing in flight, gap over
	assign send_ok = (remain != '0) && !start_pend && !o_tx_start
		&& !i_tx_busy && (gap_cnt == '0);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			remain     <= '0;
			start_pend <= 1'b0;
			gap_cnt    <= '0;
			o_tx_start <= 1'b0;
			o_busy     <= 1'b0;
		end else begin
			// start lines up with the registered lookup
			o_tx_start <= start_pend;
			if (rsp_evt) begin
				remain     <= REM_W'(NUM_CHARS);
				start_pend <= 1'b0;
				o_busy     <= 1'b1;
			end else if (send_ok) begin
				remain     <= remain - 1'b1;
				start_pend <= 1'b1;
				gap_cnt    <= GAP_W'(`DBG_TX_GAP);
			end else begin
				start_pend <= 1'b0;
				if (gap_cnt != '0)
					gap_cnt <= gap_cnt - 1'b1;
				// released once the tag char has started
				if (o_tx_start && remain == '0)
					o_busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (rsp_evt) begin
			word <= {kind_tag(rsp.kind), rsp.data};
		end else if (send_ok) begin
			// low nibble first
			nib  <= word[3:0];
			word <= {4'h0, word[4*NUM_CHARS-1:4]};
		end
		o_char <= nib_ascii(nib);
	end

endmodule

// File: src/uart_dbg_bridge.sv
`include "dbg_macros.svh"

module uart_dbg_bridge (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_rx,
	output logic       o_tx,
	output logic [7:0] o_leds
);
	import dbg_pkg::*;

	logic [7:0]             rx_data;
	logic                   rx_valid;
	bus_req_t               req;
	logic                   req_stb;
	logic                   dec_err;
	logic                   ack;
	logic [`DBG_DATA_W-1:0] rdata;
	logic                   enc_busy;
	logic [7:0]             tx_char;
	logic                   tx_start;
	logic                   tx_busy;

	uart_rx u_rx (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rx    (i_rx),
		.o_data  (rx_data),
		.o_valid (rx_valid)
	);

	// busy from the encoder holds off new commands
	hex_cmd_decoder u_dec (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_byte    (rx_data),
		.i_valid   (rx_valid),
		.i_busy    (enc_busy),
		.o_req     (req),
		.o_req_stb (req_stb),
		.o_err     (dec_err)
	);

	dbg_regfile u_regs (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_req     (req),
		.i_req_stb (req_stb),
		.o_ack     (ack),
		.o_rdata   (rdata),
		.o_leds    (o_leds)
	);

	// response kind from the held request
	hex_rsp_encoder u_enc (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_ack      (ack),
		.i_write    (req.write),
		.i_rdata    (rdata),
		.i_err      (dec_err),
		.i_tx_busy  (tx_busy),
		.o_char     (tx_char),
		.o_tx_start (tx_start),
		.o_busy     (enc_busy)
	);

	uart_tx u_tx (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_data  (tx_char),
		.i_start (tx_start),
		.o_tx    (o_tx),
		.o_busy  (tx_busy)
	);

endmodule

// File: verif/tb_uart_dbg_bridge.sv
`include "dbg_macros.svh"

module tb_uart_dbg_bridge;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF = 20;
	localparam int CLKS_PER_BIT = `DBG_CLKS_PER_BIT;
	localparam int BIT_NS = CLKS_PER_BIT * 2 * CLK_HALF;
	// longest command, 7 chars in plus 5 chars out with gaps
	localparam int CMD_CYCLES = 12 * 10 * CLKS_PER_BIT + 5 * `DBG_TX_GAP;
	// 3 + 4 + 32 + 7 + 3 commands over the five tests
	localparam int NUM_CMDS = 49;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * CMD_CYCLES * 3 / 2;

	logic        i_clk;
	logic        i_rst_n;
	logic        i_rx;
	logic        o_tx;
	logic [7:0]  o_leds;

	// expected register contents
	logic [15:0] model [16];
	// bytes of the next command line
	logic [7:0]  line_q [$];
	// five response chars, first received in the top byte
	logic [39:0] rsp_word;
	logic [31:0] lcg_state;
	int          cycle_cnt;
	int          err_cnt;
	int          check_cnt;
	int          test_cnt;

	uart_dbg_bridge DUT (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rx    (i_rx),
		.o_tx    (o_tx),
		.o_leds  (o_leds)
	);

	always #CLK_HALF i_clk = ~i_clk;

	// run limit
	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles, response never completed", cycle_cnt);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// ascii hex digit, case selectable
	function automatic logic [7:0] hex_char(input logic [3:0] n, input bit upper);
		if (n < 4'd10)
			return "0" + {4'h0, n};
		else if (upper)
			return "A" + {4'h0, n} - 8'd10;
		else
			return "a" + {4'h0, n} - 8'd10;
	endfunction

	// low nibble first, lowercase, tag last
	function automatic logic [39:0] expect_rsp(input logic [15:0] d, input logic [3:0] tag);
		return {hex_char(d[3:0], 0), hex_char(d[7:4], 0), hex_char(d[11:8], 0),
			hex_char(d[15:12], 0), hex_char(tag, 0)};
	endfunction

	task automatic check_eq(input string name, input logic [39:0] got,
		input logic [39:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// start bit, 8 data bits lsb first, stop bit
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge i_clk);
			#2 i_rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge i_clk);
		end
	endtask

	// samples mid bit, returns in the middle of the stop bit
	task automatic receive_byte(output logic [7:0] b);
		@(negedge o_tx);
		#(BIT_NS / 2);
		if (o_tx !== 1'b0) begin
			err_cnt++;
			$display("start bit on o_tx did not stay low");
		end
		for (int i = 0; i < 8; i++) begin
			#(BIT_NS);
			b[i] = o_tx;
		end
		#(BIT_NS);
		if (o_tx !== 1'b1) begin
			err_cnt++;
			$display("stop bit on o_tx was low");
		end
	endtask

	task automatic receive_response();
		logic [7:0] b;
		repeat (5) begin
			receive_byte(b);
			rsp_word = {rsp_word[31:0], b};
		end
	endtask

	// response may start before the line is fully sent
	task automatic exchange();
		fork
			begin
				for (int i = 0; i < line_q.size(); i++)
					send_byte(line_q[i]);
			end
			receive_response();
		join
		@(posedge i_clk);
		#2;
	endtask

	task automatic queue_write(input logic [3:0] addr, input logic [15:0] data,
		input bit upper);
		line_q.delete();
		line_q.push_back(upper ? "W" : "w");
		line_q.push_back(hex_char(addr, upper));
		// data msd first
		for (int i = 3; i >= 0; i--)
			line_q.push_back(hex_char(data[4*i +: 4], upper));
		line_q.push_back(8'h0d);
	endtask

	task automatic queue_read(input logic [3:0] addr, input bit upper);
		line_q.delete();
		line_q.push_back(upper ? "R" : "r");
		line_q.push_back(hex_char(addr, upper));
		line_q.push_back(8'h0d);
	endtask

	task automatic do_write(input logic [3:0] addr, input logic [15:0] data, input bit upper);
		queue_write(addr, data, upper);
		exchange();
		model[addr] = data;
		check_eq($sformatf("o_tx write reg %0h", addr), rsp_word, expect_rsp(data, 4'h1));
	endtask

	task automatic do_read(input logic [3:0] addr, input bit upper);
		queue_read(addr, upper);
		exchange();
		check_eq($sformatf("o_tx read reg %0h", addr), rsp_word, expect_rsp(model[addr], 4'h2));
	endtask

	// malformed line, cr appended
	task automatic do_bad(input string s);
		line_q.delete();
		for (int i = 0; i < s.len(); i++)
			line_q.push_back(s[i]);
		line_q.push_back(8'h0d);
		exchange();
		check_eq({"o_tx error for ", s}, rsp_word, expect_rsp(16'h0000, 4'he));
	endtask

	task automatic expect_line_idle(input int cycles);
		bit seen;
		seen = 0;
		repeat (cycles) begin
			@(negedge i_clk);
			if (o_tx !== 1'b1)
				seen = 1;
		end
		if (seen) begin
			err_cnt++;
			$display("o_tx became active with no command pending, a terminator got an answer");
		end
	endtask

	task automatic end_test(input string name, input int start_errs);
		test_cnt++;
		if (err_cnt == start_errs)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_cnt - start_errs);
	endtask

	task automatic test_reset_reads();
		int start_errs;
		start_errs = err_cnt;
		check_eq("o_tx", o_tx, 40'h1);
		check_eq("o_leds", o_leds, 40'h0);
		do_read(4'h0, 0);
		do_read(4'h5, 1);
		do_read(4'hf, 0);
		end_test("reset_reads", start_errs);
	endtask

	task automatic test_write_read();
		int start_errs;
		start_errs = err_cnt;
		do_write(4'h3, 16'ha5c9, 0);
		do_read(4'h3, 1);
		// uppercase opcode and digits
		do_write(4'hc, 16'h1f0e, 1);
		do_read(4'hc, 0);
		end_test("write_read", start_errs);
	endtask

	task automatic test_random_all();
		int start_errs;
		logic [31:0] r;
		start_errs = err_cnt;
		for (int a = 0; a < 16; a++) begin
			r = lcg_next();
			do_write(4'(a), r[31:16], a[0]);
		end
		for (int a = 0; a < 16; a++)
			do_read(4'(a), a[1]);
		end_test("random_all", start_errs);
	endtask

	task automatic test_malformed();
		int start_errs;
		start_errs = err_cnt;
		// illegal char, short data, unknown opcode
		do_bad("w2x00");
		do_bad("w512");
		do_bad("q3");
		do_write(4'h7, 16'hbeef, 0);
		do_read(4'h7, 0);
		do_read(4'h2, 0);
		do_read(4'h5, 1);
		end_test("malformed", start_errs);
	endtask

	task automatic test_leds_crlf();
		int start_errs;
		logic [31:0] r;
		start_errs = err_cnt;
		r = lcg_next();
		do_write(4'h0, r[31:16], 0);
		check_eq("o_leds", o_leds, model[0][7:0]);
		r = lcg_next();
		do_write(4'h9, r[31:16], 1);
		check_eq("o_leds", o_leds, model[0][7:0]);
		// cr lf pair, one answer only
		queue_read(4'h0, 0);
		line_q.push_back(8'h0a);
		exchange();
		check_eq("o_tx read reg 0", rsp_word, expect_rsp(model[0], 4'h2));
		expect_line_idle(30 * CLKS_PER_BIT);
		// lone lf while the decoder idles and nothing is busy
		fork
			send_byte(8'h0a);
			expect_line_idle(30 * CLKS_PER_BIT);
		join
		end_test("leds_crlf", start_errs);
	endtask

	initial begin
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		i_rx = 1'b1;
		lcg_state = 32'd94478;
		cycle_cnt = 0;
		err_cnt = 0;
		check_cnt = 0;
		test_cnt = 0;
		rsp_word = '0;
		for (int i = 0; i < 16; i++)
			model[i] = '0;
		repeat (5) @(posedge i_clk);
		#2 i_rst_n = 1'b1;
		@(posedge i_clk);
		#2;
		test_reset_reads();
		test_write_read();
		test_random_all();
		test_malformed();
		test_leds_crlf();
		$display("%0d tests run, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: sources.f
+incdir+src
src/dbg_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/hex_cmd_decoder.sv
src/dbg_regfile.sv
src/hex_rsp_encoder.sv
src/uart_dbg_bridge.sv
verif/tb_uart_dbg_bridge.sv
